/* hw/misc_ctrl_pkg.sv */
`default_nettype none

package misc_ctrl_pkg;

	//--------------------------------------------------------------------------
	// Host bus widths
	//--------------------------------------------------------------------------

	// Address and data of the asynchronous chip-select bus
	typedef logic [7:0] addr_t;
	typedef logic [7:0] data_t;

	// Active-low selects, bit n belongs to bank n
	typedef logic [3:1] cs_vec_t;

	// Misc registers answer on chip select 3
	localparam int MISC_BANK = 3;

	//--------------------------------------------------------------------------
	// Misc bank register map
	//--------------------------------------------------------------------------

	// Watchdog enable in bit 0, feed bit in bit 1
	localparam addr_t OFS_WDG        = 8'h00;
	localparam addr_t OFS_IO_LED     = 8'h02;
	localparam addr_t OFS_RELAY_EN   = 8'h03;
	localparam addr_t OFS_RELAY_CTRL = 8'h04;
	// LCD backlight in bit 1, LVDS power in bit 0
	localparam addr_t OFS_LVDS       = 8'h0a;
	// First of six read-only ID bytes
	localparam addr_t OFS_SYS_ID     = 8'h20;

	// Board identification, lowest offset first
	localparam data_t SYS_ID [6] = '{8'h9a, 8'hf4, 8'h6c, 8'h7f, 8'hde, 8'h13};

	// RUN LED on and LVDS powered out of reset
	localparam logic [3:0] RST_IO_LED = 4'h1;
	localparam logic [1:0] RST_LVDS   = 2'h1;

	//--------------------------------------------------------------------------
	// Stage structs
	//--------------------------------------------------------------------------

	// One write request, valid for a single cycle
	typedef struct packed {
		logic  valid;
		addr_t addr;
		data_t data;
	} bus_wr_t;

	// Read window, follows the pins
	typedef struct packed {
		logic  active;
		addr_t addr;
	} bus_rd_t;

	// Stored register bits
	typedef struct packed {
		logic       wdg_en;
		logic       wdg_pwm;
		logic [3:0] io_led;
		logic [3:0] relay_en;
		logic [3:0] relay_ctl;
		logic [1:0] lvds;
	} misc_regs_t;

endpackage

`default_nettype wire

/* hw/gpmc_bus_capture.sv */
`default_nettype none

module gpmc_bus_capture
	import misc_ctrl_pkg::*;
(
	input  wire          fpga_clk,
	input  wire          sys_rst_n,
	input  wire cs_vec_t gpmc_cs_n,
	input  wire          gpmc_we_n,
	input  wire          gpmc_oe_n,
	input  wire addr_t   sa,
	input  wire data_t   sd_in,
	output bus_wr_t      wr,
	output bus_rd_t      rd
);

	// Two-flop synchronizers, still active low
	logic [1:0] we_sync;
	logic [1:0] cs_sync;
	// Previous synchronized strobe for edge detection
	logic       we_prev;
	logic       we_fall;
	logic       wr_valid;
	addr_t      wr_addr;
	data_t      wr_data;

	//--------------------------------------------------------------------------
	// Strobe resynchronization
	//--------------------------------------------------------------------------

	always_ff @(posedge fpga_clk or negedge sys_rst_n)
	begin
		if (!sys_rst_n)
		begin
			we_sync  <= 2'b11;
			cs_sync  <= 2'b11;
			we_prev  <= 1'b1;
			wr_valid <= 1'b0;
		end
		else
		begin
			we_sync  <= {we_sync[0], gpmc_we_n};
			cs_sync  <= {cs_sync[0], gpmc_cs_n[MISC_BANK]};
			we_prev  <= we_sync[1];
			// Single-cycle request on the third edge
			wr_valid <= we_fall;
		end
	end

	// Strobe went low while the misc bank is selected
	assign we_fall = we_prev & ~we_sync[1] & ~cs_sync[1];

	// Host keeps sa and sd_in stable across the strobe
	always_ff @(posedge fpga_clk)
	begin
		if (we_fall)
		begin
			wr_addr <= sa;
			wr_data <= sd_in;
		end
	end

	assign wr.valid = wr_valid;
	assign wr.addr  = wr_addr;
	assign wr.data  = wr_data;

	// Read window straight from the pins
	assign rd.active = ~gpmc_cs_n[MISC_BANK] & ~gpmc_oe_n;
	assign rd.addr   = sa;

endmodule

`default_nettype wire

/* hw/misc_reg_bank.sv */
`default_nettype none

module misc_reg_bank
	import misc_ctrl_pkg::*;
(
	input  wire          fpga_clk,
	input  wire          sys_rst_n,
	input  wire bus_wr_t wr,
	input  wire bus_rd_t rd,
	output misc_regs_t   regs,
	output data_t        sd_out,
	output logic         sd_oe
);

	// Read mux result before output gating
	data_t rd_data;
	logic  rd_hit;
	// Distance from the first ID byte, wraps above for lower offsets
	addr_t id_ofs;

	//--------------------------------------------------------------------------
	// Register write
	//--------------------------------------------------------------------------

	always_ff @(posedge fpga_clk or negedge sys_rst_n)
	begin
		if (!sys_rst_n)
		begin
			regs.wdg_en    <= 1'b0;
			regs.wdg_pwm   <= 1'b0;
			regs.io_led    <= RST_IO_LED;
			regs.relay_en  <= 4'h0;
			regs.relay_ctl <= 4'h0;
			regs.lvds      <= RST_LVDS;
		end
		else if (wr.valid)
		begin
			// Only the defined low bits are kept
			case (wr.addr)
				OFS_WDG:
				begin
					regs.wdg_en  <= wr.data[0];
					regs.wdg_pwm <= wr.data[1];
				end
				OFS_IO_LED:
					regs.io_led <= wr.data[3:0];
				OFS_RELAY_EN:
					regs.relay_en <= wr.data[3:0];
				OFS_RELAY_CTRL:
					regs.relay_ctl <= wr.data[3:0];
				OFS_LVDS:
					regs.lvds <= wr.data[1:0];
				// ID bytes and holes in the map are not writable
				default:
				begin
				end
			endcase
		end
	end

	//--------------------------------------------------------------------------
	// Read-back mux
	//--------------------------------------------------------------------------

	assign id_ofs = rd.addr - OFS_SYS_ID;

	always_comb
	begin
		rd_data = '0;
		rd_hit  = 1'b1;
		case (rd.addr)
			OFS_WDG:
				rd_data = {6'h0, regs.wdg_pwm, regs.wdg_en};
			OFS_IO_LED:
				rd_data = {4'h0, regs.io_led};
			OFS_RELAY_EN:
				rd_data = {4'h0, regs.relay_en};
			OFS_RELAY_CTRL:
				rd_data = {4'h0, regs.relay_ctl};
			OFS_LVDS:
				rd_data = {6'h0, regs.lvds};
			default:
			begin
				// System ID window, everything else is unmapped
				if (id_ofs < 8'd6)
				begin
					rd_data = SYS_ID[id_ofs[2:0]];
				end
				else
				begin
					rd_hit = 1'b0;
				end
			end
		endcase
	end

	// Drive the bus only for a mapped offset inside the read window
	assign sd_oe  = rd.active & rd_hit;
	assign sd_out = sd_oe ? rd_data : '0;

endmodule

`default_nettype wire

/* hw/watchdog_pulse.sv */
`default_nettype none

module watchdog_pulse
	import misc_ctrl_pkg::*;
#(
	parameter int WDG_CNT_WIDTH = 24
)
(
	input  wire             fpga_clk,
	input  wire             sys_rst_n,
	input  wire misc_regs_t regs,
	output logic            wdg_out,
	output logic            heartbeat
);

	// Free-running divider, top bit toggles the heartbeat
	logic [WDG_CNT_WIDTH-1:0] wdg_cnt;

	always_ff @(posedge fpga_clk or negedge sys_rst_n)
	begin
		if (!sys_rst_n)
		begin
			wdg_cnt <= '0;
		end
		else
		begin
			wdg_cnt <= wdg_cnt + 1'b1;
		end
	end

	assign heartbeat = wdg_cnt[WDG_CNT_WIDTH-1];

	// Heartbeat feeds the external watchdog until software enables
	// its own feed bit
	assign wdg_out = regs.wdg_en ? regs.wdg_pwm : heartbeat;

endmodule

`default_nettype wire

/* hw/panel_output.sv */
`default_nettype none

module panel_output
	import misc_ctrl_pkg::*;
(
	input  wire misc_regs_t regs,
	output logic [3:0]      relay_ctrl,
	output logic [3:0]      io_led_out,
	output logic            lcd_vled,
	output logic            lvds_pwen
);

	// Relay drive after enable masking
	logic [3:0] relay_on;
	// Heater indications, one per heater pair
	logic       sio2_heat;
	logic       filter_heat;

	//--------------------------------------------------------------------------
	// Relays
	//--------------------------------------------------------------------------

	// A relay only switches when it is enabled
	assign relay_on   = regs.relay_ctl & regs.relay_en;
	assign relay_ctrl = relay_on;

	//--------------------------------------------------------------------------
	// IO LEDs, all active low
	//--------------------------------------------------------------------------

	// SIO2 heaters on relays 0 and 1
	assign sio2_heat   = regs.io_led[2] | relay_on[0] | relay_on[1];
	// Filter and case heaters on relays 2 and 3
	assign filter_heat = regs.io_led[3] | relay_on[2] | relay_on[3];

	// RUN and ERR straight from the register
	assign io_led_out[1:0] = ~regs.io_led[1:0];
	assign io_led_out[2]   = ~sio2_heat;
	assign io_led_out[3]   = ~filter_heat;

	// LVDS panel power and backlight
	assign lcd_vled  = regs.lvds[1];
	assign lvds_pwen = regs.lvds[0];

endmodule

`default_nettype wire

/* hw/misc_ctrl_top.sv */
`default_nettype none

module misc_ctrl_top
	import misc_ctrl_pkg::*;
#(
	parameter int WDG_CNT_WIDTH = 24
)
(
	input  wire          fpga_clk,
	input  wire          sys_rst_n,
	// Host chip-select bus
	input  wire cs_vec_t gpmc_cs_n,
	input  wire          gpmc_we_n,
	input  wire          gpmc_oe_n,
	input  wire addr_t   sa,
	input  wire data_t   sd_in,
	// Split data bus, the board top adds the tristate pad
	output data_t        sd_out,
	output logic         sd_oe,
	// Board outputs
	output logic         wdg_out,
	output logic         heartbeat,
	output logic [3:0]   relay_ctrl,
	output logic [3:0]   io_led_out,
	output logic         lcd_vled,
	output logic         lvds_pwen
);

	// Stage to stage links
	bus_wr_t    wr;
	bus_rd_t    rd;
	misc_regs_t regs;

	//--------------------------------------------------------------------------
	// Bus capture and register bank
	//--------------------------------------------------------------------------

	gpmc_bus_capture u_capture (
		.fpga_clk  (fpga_clk),
		.sys_rst_n (sys_rst_n),
		.gpmc_cs_n (gpmc_cs_n),
		.gpmc_we_n (gpmc_we_n),
		.gpmc_oe_n (gpmc_oe_n),
		.sa        (sa),
		.sd_in     (sd_in),
		.wr        (wr),
		.rd        (rd)
	);

	misc_reg_bank u_regs (
		.fpga_clk  (fpga_clk),
		.sys_rst_n (sys_rst_n),
		.wr        (wr),
		.rd        (rd),
		.regs      (regs),
		.sd_out    (sd_out),
		.sd_oe     (sd_oe)
	);

	//--------------------------------------------------------------------------
	// Board outputs
	//--------------------------------------------------------------------------

	watchdog_pulse #(
		.WDG_CNT_WIDTH (WDG_CNT_WIDTH)
	) u_wdg (
		.fpga_clk  (fpga_clk),
		.sys_rst_n (sys_rst_n),
		.regs      (regs),
		.wdg_out   (wdg_out),
		.heartbeat (heartbeat)
	);

	panel_output u_panel (
		.regs       (regs),
		.relay_ctrl (relay_ctrl),
		.io_led_out (io_led_out),
		.lcd_vled   (lcd_vled),
		.lvds_pwen  (lvds_pwen)
	);

endmodule

`default_nettype wire

/* tests/misc_ctrl_tb.sv */
`default_nettype none

module misc_ctrl_tb;

	localparam int CNT_W = 6;
	// Tests run about 800 cycles, watchdog allows roughly twice that
	localparam int TIMEOUT_CYCLES = 2000;
	// Active-low chip selects, bit 3 on the left
	localparam logic [3:1] SEL_MISC  = 3'b011;
	localparam logic [3:1] SEL_BANK1 = 3'b110;
	localparam logic [3:1] SEL_NONE  = 3'b111;
	// Writable offsets, then the six ID offsets
	localparam logic [7:0] MAP_OFS [11] = '{8'h00, 8'h02, 8'h03, 8'h04, 8'h0a,
		8'h20, 8'h21, 8'h22, 8'h23, 8'h24, 8'h25};

	logic       fpga_clk;
	logic       sys_rst_n;
	logic [3:1] gpmc_cs_n;
	logic       gpmc_we_n;
	logic       gpmc_oe_n;
	logic [7:0] sa;
	logic [7:0] sd_in;
	logic [7:0] sd_out;
	logic       sd_oe;
	logic       wdg_out;
	logic       heartbeat;
	logic [3:0] relay_ctrl;
	logic [3:0] io_led_out;
	logic       lcd_vled;
	logic       lvds_pwen;

	// Register model, {pwm, en} for the watchdog
	logic [1:0]  m_wdg;
	logic [3:0]  m_io_led;
	logic [3:0]  m_relay_en;
	logic [3:0]  m_relay_ctl;
	logic [1:0]  m_lvds;
	// Heartbeat divider model
	logic [CNT_W-1:0] hb_cnt;
	logic [31:0] lfsr_state;
	int          err_count;
	int          test_errs;
	int          tests_passed;
	int          tests_failed;

	misc_ctrl_top #(
		.WDG_CNT_WIDTH (CNT_W)
	) dut0 (
		.fpga_clk   (fpga_clk),
		.sys_rst_n  (sys_rst_n),
		.gpmc_cs_n  (gpmc_cs_n),
		.gpmc_we_n  (gpmc_we_n),
		.gpmc_oe_n  (gpmc_oe_n),
		.sa         (sa),
		.sd_in      (sd_in),
		.sd_out     (sd_out),
		.sd_oe      (sd_oe),
		.wdg_out    (wdg_out),
		.heartbeat  (heartbeat),
		.relay_ctrl (relay_ctrl),
		.io_led_out (io_led_out),
		.lcd_vled   (lcd_vled),
		.lvds_pwen  (lvds_pwen)
	);

	initial
	begin
		fpga_clk = 1'b0;
		forever #2 fpga_clk = ~fpga_clk;
	end

	// Free-running from the release of reset, top bit is the heartbeat
	always @(posedge fpga_clk or negedge sys_rst_n)
	begin
		if (!sys_rst_n)
			hb_cnt <= '0;
		else
			hb_cnt <= hb_cnt + 1'b1;
	end

	// --------------------------------------------------------------------------
	// Reference model
	// --------------------------------------------------------------------------

	// Expected {sd_oe, sd_out} for a read of addr
	function automatic logic [8:0] expected_read(input logic [7:0] addr);
		logic [8:0] r;
		case (addr)
			8'h00: r = {1'b1, 6'h0, m_wdg};
			8'h02: r = {1'b1, 4'h0, m_io_led};
			8'h03: r = {1'b1, 4'h0, m_relay_en};
			8'h04: r = {1'b1, 4'h0, m_relay_ctl};
			8'h0a: r = {1'b1, 6'h0, m_lvds};
			// System ID bytes
			8'h20: r = {1'b1, 8'h9a};
			8'h21: r = {1'b1, 8'hf4};
			8'h22: r = {1'b1, 8'h6c};
			8'h23: r = {1'b1, 8'h7f};
			8'h24: r = {1'b1, 8'hde};
			8'h25: r = {1'b1, 8'h13};
			// Unmapped, bus stays released
			default: r = 9'h000;
		endcase
		return r;
	endfunction

	// Expected {relay_ctrl, io_led_out, lcd_vled, lvds_pwen}
	function automatic logic [9:0] expected_board();
		logic [3:0] relay;
		logic [3:0] led;
		relay  = m_relay_ctl & m_relay_en;
		// LEDs are active low
		led[0] = ~m_io_led[0];
		led[1] = ~m_io_led[1];
		led[2] = ~(m_io_led[2] | relay[0] | relay[1]);
		led[3] = ~(m_io_led[3] | relay[2] | relay[3]);
		return {relay, led, m_lvds[1], m_lvds[0]};
	endfunction

	// Misc bank write as seen by the model, defined bits only
	task automatic model_write(input logic [7:0] addr, input logic [7:0] data);
		case (addr)
			8'h00: m_wdg = data[1:0];
			8'h02: m_io_led = data[3:0];
			8'h03: m_relay_en = data[3:0];
			8'h04: m_relay_ctl = data[3:0];
			8'h0a: m_lvds = data[1:0];
			default: ;
		endcase
	endtask

	// Galois LFSR, one step per bit taken
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
			v = {v[6:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
			err_count++;
			test_errs++;
		end
	endtask

	task automatic end_test(input string name);
		if (test_errs == 0)
		begin
			tests_passed++;
			$display("Test %s: passed", name);
		end
		else
		begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	// --------------------------------------------------------------------------
	// Bus tasks
	// --------------------------------------------------------------------------

	// Strobe low 6 cycles, then 2 idle cycles
	task automatic bus_write(input logic [3:1] cs, input logic [7:0] addr,
		input logic [7:0] data);
		@(posedge fpga_clk);
		gpmc_cs_n <= cs;
		sa        <= addr;
		sd_in     <= data;
		gpmc_we_n <= 1'b0;
		repeat (6) @(posedge fpga_clk);
		gpmc_we_n <= 1'b1;
		gpmc_cs_n <= SEL_NONE;
		repeat (2) @(posedge fpga_clk);
	endtask

	// Read strobe low 2 cycles, sampled mid-cycle
	task automatic bus_read(input logic [7:0] addr, output logic [8:0] result);
		@(posedge fpga_clk);
		gpmc_cs_n <= SEL_MISC;
		sa        <= addr;
		gpmc_oe_n <= 1'b0;
		@(posedge fpga_clk);
		@(negedge fpga_clk);
		result = {sd_oe, sd_out};
		@(posedge fpga_clk);
		gpmc_oe_n <= 1'b1;
		gpmc_cs_n <= SEL_NONE;
	endtask

	task automatic read_check(input string name, input logic [7:0] addr);
		logic [8:0] got;
		bus_read(addr, got);
		check(name, expected_read(addr), got);
	endtask

	task automatic board_check(input string name);
		@(negedge fpga_clk);
		check(name, expected_board(), {relay_ctrl, io_led_out, lcd_vled, lvds_pwen});
	endtask

	// Watchdog
	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge fpga_clk);
		$display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	// --------------------------------------------------------------------------
	// Test sequence
	// --------------------------------------------------------------------------

	initial
	begin
		logic [7:0] d;
		logic [7:0] en;
		logic [7:0] ctl;
		logic       first;
		logic       toggled;
		sys_rst_n    = 1'b0;
		gpmc_cs_n    = SEL_NONE;
		gpmc_we_n    = 1'b1;
		gpmc_oe_n    = 1'b1;
		sa           = 8'h00;
		sd_in        = 8'h00;
		lfsr_state   = 32'h1d78e68b;
		err_count    = 0;
		test_errs    = 0;
		tests_passed = 0;
		tests_failed = 0;
		// Reset contents of the bank
		m_wdg        = 2'b00;
		m_io_led     = 4'h1;
		m_relay_en   = 4'h0;
		m_relay_ctl  = 4'h0;
		m_lvds       = 2'b01;
		repeat (10) @(posedge fpga_clk);
		sys_rst_n <= 1'b1;
		@(posedge fpga_clk);

		// Heartbeat counter still low right after reset
		@(negedge fpga_clk);
		check("reset sd_oe", 1'b0, sd_oe);
		check("reset heartbeat", 1'b0, heartbeat);
		check("reset wdg_out", 1'b0, wdg_out);
		board_check("reset board outputs");
		foreach (MAP_OFS[i])
			read_check("reset read", MAP_OFS[i]);
		end_test("reset values");

		for (int i = 0; i < 5; i++)
		begin
			d = rand_bits(8);
			bus_write(SEL_MISC, MAP_OFS[i], d);
			model_write(MAP_OFS[i], d);
			read_check("register readback", MAP_OFS[i]);
		end
		for (int i = 5; i < 11; i++)
			read_check("system id", MAP_OFS[i]);
		read_check("unmapped 0x01", 8'h01);
		read_check("unmapped 0x26", 8'h26);
		// Other bank and ID writes leave the model untouched
		bus_write(SEL_BANK1, 8'h02, {4'h0, ~m_io_led});
		read_check("bank 1 write", 8'h02);
		bus_write(SEL_MISC, 8'h20, 8'h55);
		read_check("id write ignored", 8'h20);
		end_test("register read-back");

		repeat (20)
		begin
			en  = rand_bits(4);
			ctl = rand_bits(4);
			bus_write(SEL_MISC, 8'h03, en);
			model_write(8'h03, en);
			bus_write(SEL_MISC, 8'h04, ctl);
			model_write(8'h04, ctl);
			board_check("relay masking");
		end
		end_test("relay masking and heater LEDs");

		for (int v = 0; v < 4; v++)
		begin
			bus_write(SEL_MISC, 8'h0a, 8'(v));
			model_write(8'h0a, 8'(v));
			board_check("lvds outputs");
		end
		end_test("LVDS outputs");

		// Heartbeat must show within one counter period
		bus_write(SEL_MISC, 8'h00, 8'h00);
		model_write(8'h00, 8'h00);
		@(negedge fpga_clk);
		first   = wdg_out;
		toggled = 1'b0;
		repeat ((1 << CNT_W) + 8)
		begin
			@(negedge fpga_clk);
			check("heartbeat", hb_cnt[CNT_W-1], heartbeat);
			check("wdg_out heartbeat", hb_cnt[CNT_W-1], wdg_out);
			if (wdg_out !== first)
				toggled = 1'b1;
		end
		if (!toggled)
		begin
			$display("wdg_out never changed while the watchdog enable was clear");
			err_count++;
			test_errs++;
		end
		d = rand_bits(1);
		bus_write(SEL_MISC, 8'h00, {6'h0, d[0], 1'b1});
		model_write(8'h00, {6'h0, d[0], 1'b1});
		repeat (200)
		begin
			@(negedge fpga_clk);
			check("wdg_pwm hold", d[0], wdg_out);
			check("heartbeat running", hb_cnt[CNT_W-1], heartbeat);
		end
		end_test("watchdog");

		$display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
			err_count);
		if (tests_failed == 0 && err_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
hw/misc_ctrl_pkg.sv
hw/gpmc_bus_capture.sv
hw/misc_reg_bank.sv
hw/watchdog_pulse.sv
hw/panel_output.sv
hw/misc_ctrl_top.sv
tests/misc_ctrl_tb.sv

/* Bender.yml */
package:
  name: misc_ctrl

sources:
  - hw/misc_ctrl_pkg.sv
  - hw/gpmc_bus_capture.sv
  - hw/misc_reg_bank.sv
  - hw/watchdog_pulse.sv
  - hw/panel_output.sv
  - hw/misc_ctrl_top.sv
  - target: test
    files:
      - tests/misc_ctrl_tb.sv
